// File: Bender.yml
package:
  name: mips_cpu

sources:
  - hdl/mips_pkg.sv
  - hdl/mips_fetch.sv
  - hdl/mips_regfile.sv
  - hdl/mips_decode.sv
  - hdl/mips_execute.sv
  - hdl/mips_memory.sv
  - hdl/mips_cpu.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/mips_cpu_tb.sv

// File: hdl/mips_cpu.sv
// Top level of the five-stage MIPS pipeline, stages and register file wired together
`timescale 1ns/1ns

module mips_cpu #(
   parameter int IMEM_WORDS = 64,
   parameter int DMEM_WORDS = 32
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   input  mips_pkg::word_t               imem_wdata,
   output mips_pkg::word_t               pc,
   output logic                          wb_en,
   output mips_pkg::reg_addr_t           wb_reg,
   output mips_pkg::word_t               wb_data
);
   // Fetch/decode and redirect
   mips_pkg::word_t     if_instr;
   mips_pkg::word_t     if_pc4;
   logic                stall;
   logic                branch_taken;
   mips_pkg::word_t     branch_target;

   // Register file ports
   mips_pkg::reg_addr_t rs;
   mips_pkg::reg_addr_t rt;
   mips_pkg::word_t     rs_data;
   mips_pkg::word_t     rt_data;
   logic                rf_we;
   mips_pkg::reg_addr_t rf_waddr;
   mips_pkg::word_t     rf_wdata;

   // Decode/execute register
   mips_pkg::reg_addr_t id_rs;
   mips_pkg::reg_addr_t id_rt;
   mips_pkg::reg_addr_t id_dest;
   mips_pkg::word_t     id_rs_data;
   mips_pkg::word_t     id_rt_data;
   mips_pkg::word_t     id_imm_ext;
   mips_pkg::word_t     id_branch_target;
   mips_pkg::alu_op_t   id_alu_op;
   logic                id_use_imm;
   logic                id_mem_read;
   logic                id_mem_write;
   logic                id_reg_write;
   mips_pkg::branch_t   id_branch;
   logic                ex_mem_read;
   mips_pkg::reg_addr_t ex_dest;

   // Execute/memory register
   mips_pkg::word_t     mem_alu_result;
   mips_pkg::word_t     mem_store_data;
   mips_pkg::reg_addr_t mem_dest;
   logic                mem_reg_write;
   logic                mem_mem_read;
   logic                mem_mem_write;
   mips_pkg::branch_t   mem_branch;
   logic                mem_zero;
   mips_pkg::word_t     mem_branch_target;

   // Port names match the wires above
   mips_fetch #(.IMEM_WORDS(IMEM_WORDS)) mips_fetch_inst (.*);

   mips_regfile mips_regfile_inst (.*);

   mips_decode mips_decode_inst (.*);

   mips_execute mips_execute_inst (.*);

   mips_memory #(.DMEM_WORDS(DMEM_WORDS)) mips_memory_inst (.*);

endmodule

// File: hdl/mips_decode.sv
// Decode stage: fields, control, branch target, load-use detection and decode/execute register
`timescale 1ns/1ns

module mips_decode (
   input  logic                clk,
   input  logic                arst_n,
   input  mips_pkg::word_t     if_instr,
   input  mips_pkg::word_t     if_pc4,
   input  mips_pkg::word_t     rs_data,
   input  mips_pkg::word_t     rt_data,
   input  logic                ex_mem_read,
   input  mips_pkg::reg_addr_t ex_dest,
   input  logic                branch_taken,
   output logic                stall,
   output mips_pkg::reg_addr_t rs,
   output mips_pkg::reg_addr_t rt,
   output mips_pkg::reg_addr_t id_rs,
   output mips_pkg::reg_addr_t id_rt,
   output mips_pkg::reg_addr_t id_dest,
   output mips_pkg::word_t     id_rs_data,
   output mips_pkg::word_t     id_rt_data,
   output mips_pkg::word_t     id_imm_ext,
   output mips_pkg::word_t     id_branch_target,
   output mips_pkg::alu_op_t   id_alu_op,
   output logic                id_use_imm,
   output logic                id_mem_read,
   output logic                id_mem_write,
   output logic                id_reg_write,
   output mips_pkg::branch_t   id_branch
);
   mips_pkg::opcode_t   opcode;
   mips_pkg::funct_t    funct;
   mips_pkg::reg_addr_t rd;
   mips_pkg::imm_t      imm;
   mips_pkg::word_t     imm_ext;
   mips_pkg::reg_addr_t dest;
   mips_pkg::alu_op_t   alu_op;
   mips_pkg::branch_t   branch;
   logic                use_imm;
   logic                mem_read;
   logic                mem_write;
   logic                reg_write;
   logic                dest_is_rd;

   // Instruction fields
   assign opcode  = mips_pkg::opcode_t'(if_instr[31:26]);
   assign rs      = if_instr[25:21];
   assign rt      = if_instr[20:16];
   assign rd      = if_instr[15:11];
   assign funct   = mips_pkg::funct_t'(if_instr[5:0]);
   assign imm     = if_instr[15:0];
   assign imm_ext = {{16{imm[15]}}, imm};

   // Control, anything unknown stays a no-op
   always_comb begin
      alu_op     = mips_pkg::ALU_ADD;
      branch     = mips_pkg::BR_NONE;
      use_imm    = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      reg_write  = 1'b0;
      dest_is_rd = 1'b0;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            dest_is_rd = 1'b1;
            reg_write  = 1'b1;
            case (funct)
               mips_pkg::F_ADD: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::F_SUB: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::F_AND: alu_op = mips_pkg::ALU_AND;
               mips_pkg::F_OR:  alu_op = mips_pkg::ALU_OR;
               mips_pkg::F_SLT: alu_op = mips_pkg::ALU_SLT;
               default:         reg_write = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDI: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::OP_LW: begin
            use_imm   = 1'b1;
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::OP_SW: begin
            use_imm   = 1'b1;
            mem_write = 1'b1;
         end
         // Branches compare by subtraction
         mips_pkg::OP_BEQ: begin
            alu_op = mips_pkg::ALU_SUB;
            branch = mips_pkg::BR_EQ;
         end
         mips_pkg::OP_BNE: begin
            alu_op = mips_pkg::ALU_SUB;
            branch = mips_pkg::BR_NE;
         end
         default: ;
      endcase
   end

   assign dest = dest_is_rd ? rd : rt;

   // Load in execute feeding either source, hold one cycle
   assign stall = ex_mem_read && (ex_dest == rs || ex_dest == rt);

   // Enables go to a bubble on stall or flush
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_mem_read  <= 1'b0;
         id_mem_write <= 1'b0;
         id_reg_write <= 1'b0;
         id_branch    <= mips_pkg::BR_NONE;
      end else if (stall || branch_taken) begin
         id_mem_read  <= 1'b0;
         id_mem_write <= 1'b0;
         id_reg_write <= 1'b0;
         id_branch    <= mips_pkg::BR_NONE;
      end else begin
         id_mem_read  <= mem_read;
         id_mem_write <= mem_write;
         // r0 is never written, nor forwarded
         id_reg_write <= reg_write && (dest != '0);
         id_branch    <= branch;
      end
   end

   always_ff @(posedge clk) begin
      id_rs            <= rs;
      id_rt            <= rt;
      id_dest          <= dest;
      id_rs_data       <= rs_data;
      id_rt_data       <= rt_data;
      id_imm_ext       <= imm_ext;
      // Target is pc+4 plus the word offset
      id_branch_target <= if_pc4 + {imm_ext[29:0], 2'b00};
      id_alu_op        <= alu_op;
      id_use_imm       <= use_imm;
   end

endmodule

// File: hdl/mips_execute.sv
// Execute stage: operand forwarding, ALU and the execute/memory register
`timescale 1ns/1ns

module mips_execute (
   input  logic                clk,
   input  logic                arst_n,
   input  mips_pkg::reg_addr_t id_rs,
   input  mips_pkg::reg_addr_t id_rt,
   input  mips_pkg::reg_addr_t id_dest,
   input  mips_pkg::word_t     id_rs_data,
   input  mips_pkg::word_t     id_rt_data,
   input  mips_pkg::word_t     id_imm_ext,
   input  mips_pkg::word_t     id_branch_target,
   input  mips_pkg::alu_op_t   id_alu_op,
   input  logic                id_use_imm,
   input  logic                id_mem_read,
   input  logic                id_mem_write,
   input  logic                id_reg_write,
   input  mips_pkg::branch_t   id_branch,
   input  logic                branch_taken,
   input  logic                rf_we,
   input  mips_pkg::reg_addr_t rf_waddr,
   input  mips_pkg::word_t     rf_wdata,
   output logic                ex_mem_read,
   output mips_pkg::reg_addr_t ex_dest,
   output mips_pkg::word_t     mem_alu_result,
   output mips_pkg::word_t     mem_store_data,
   output mips_pkg::reg_addr_t mem_dest,
   output logic                mem_reg_write,
   output logic                mem_mem_read,
   output logic                mem_mem_write,
   output mips_pkg::branch_t   mem_branch,
   output logic                mem_zero,
   output mips_pkg::word_t     mem_branch_target
);
   mips_pkg::word_t op_a;
   mips_pkg::word_t op_rt;
   mips_pkg::word_t op_b;
   mips_pkg::word_t alu_result;

   // Hazard view for decode
   assign ex_mem_read = id_mem_read;
   assign ex_dest     = id_dest;

   // Youngest producer first, then writeback, then the register file
   assign op_a = (mem_reg_write && mem_dest == id_rs) ? mem_alu_result :
                 (rf_we && rf_waddr == id_rs) ? rf_wdata : id_rs_data;
   assign op_rt = (mem_reg_write && mem_dest == id_rt) ? mem_alu_result :
                  (rf_we && rf_waddr == id_rt) ? rf_wdata : id_rt_data;
   assign op_b = id_use_imm ? id_imm_ext : op_rt;

   always_comb begin
      case (id_alu_op)
         mips_pkg::ALU_SUB: alu_result = op_a - op_b;
         mips_pkg::ALU_AND: alu_result = op_a & op_b;
         mips_pkg::ALU_OR:  alu_result = op_a | op_b;
         mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
         default:           alu_result = op_a + op_b;
      endcase
   end

   // Taken branch in memory kills the instruction here
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_reg_write <= 1'b0;
         mem_mem_read  <= 1'b0;
         mem_mem_write <= 1'b0;
         mem_branch    <= mips_pkg::BR_NONE;
      end else if (branch_taken) begin
         mem_reg_write <= 1'b0;
         mem_mem_read  <= 1'b0;
         mem_mem_write <= 1'b0;
         mem_branch    <= mips_pkg::BR_NONE;
      end else begin
         mem_reg_write <= id_reg_write;
         mem_mem_read  <= id_mem_read;
         mem_mem_write <= id_mem_write;
         mem_branch    <= id_branch;
      end
   end

   always_ff @(posedge clk) begin
      mem_alu_result    <= alu_result;
      // Store data uses the forwarded rt
      mem_store_data    <= op_rt;
      mem_dest          <= id_dest;
      mem_zero          <= (alu_result == '0);
      mem_branch_target <= id_branch_target;
   end

endmodule

// File: hdl/mips_fetch.sv
// Fetch stage: PC, loadable instruction memory and the fetch/decode register
`timescale 1ns/1ns

module mips_fetch #(
   parameter int IMEM_WORDS = 64
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          stall,
   input  logic                          branch_taken,
   input  mips_pkg::word_t               branch_target,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   input  mips_pkg::word_t               imem_wdata,
   output mips_pkg::word_t               pc,
   output mips_pkg::word_t               if_instr,
   output mips_pkg::word_t               if_pc4
);
   localparam int IDX_W = $clog2(IMEM_WORDS);

   mips_pkg::word_t  imem [IMEM_WORDS];
   mips_pkg::word_t  pc4;
   logic [IDX_W-1:0] pc_idx;

   // Word index wraps with the memory depth
   assign pc_idx = pc[IDX_W+1:2];
   assign pc4    = pc + 32'd4;

   // Loading port, live during reset too
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // Branch redirect beats the load-use hold
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         if_instr <= '0;
      end else if (branch_taken) begin
         pc       <= branch_target;
         // All-zero word decodes as a no-op
         if_instr <= '0;
      end else if (!stall) begin
         pc       <= pc4;
         if_instr <= imem[pc_idx];
      end
   end

   // Return address travels with the instruction
   always_ff @(posedge clk) begin
      if (!stall) begin
         if_pc4 <= pc4;
      end
   end

   // Targets come from word-scaled offsets, so the PC never misaligns
   a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
      else $error("PC lost word alignment");

endmodule

// File: hdl/mips_memory.sv
// Memory and writeback stages: data memory, branch resolution and register write port
`timescale 1ns/1ns

module mips_memory #(
   parameter int DMEM_WORDS = 32
) (
   input  logic                clk,
   input  logic                arst_n,
   input  mips_pkg::word_t     mem_alu_result,
   input  mips_pkg::word_t     mem_store_data,
   input  mips_pkg::reg_addr_t mem_dest,
   input  logic                mem_reg_write,
   input  logic                mem_mem_read,
   input  logic                mem_mem_write,
   input  mips_pkg::branch_t   mem_branch,
   input  logic                mem_zero,
   input  mips_pkg::word_t     mem_branch_target,
   output logic                branch_taken,
   output mips_pkg::word_t     branch_target,
   output logic                rf_we,
   output mips_pkg::reg_addr_t rf_waddr,
   output mips_pkg::word_t     rf_wdata,
   output logic                wb_en,
   output mips_pkg::reg_addr_t wb_reg,
   output mips_pkg::word_t     wb_data
);
   localparam int IDX_W = $clog2(DMEM_WORDS);

   mips_pkg::word_t  dmem [DMEM_WORDS];
   logic [IDX_W-1:0] dmem_idx;
   mips_pkg::word_t  load_data;
   mips_pkg::word_t  wb_alu;
   mips_pkg::word_t  wb_load;
   logic             wb_is_load;

   // Word address, wraps with the depth
   assign dmem_idx  = mem_alu_result[IDX_W+1:2];
   assign load_data = dmem[dmem_idx];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (mem_mem_write) begin
         dmem[dmem_idx] <= mem_store_data;
      end
   end

   // Resolution straight from the execute/memory register
   assign branch_taken  = (mem_branch == mips_pkg::BR_EQ && mem_zero) ||
                          (mem_branch == mips_pkg::BR_NE && !mem_zero);
   assign branch_target = mem_branch_target;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rf_we <= 1'b0;
      end else begin
         rf_we <= mem_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      rf_waddr   <= mem_dest;
      wb_alu     <= mem_alu_result;
      wb_load    <= load_data;
      wb_is_load <= mem_mem_read;
   end

   // Writeback select
   assign rf_wdata = wb_is_load ? wb_load : wb_alu;

   // Trace mirrors the write port
   assign wb_en   = rf_we;
   assign wb_reg  = rf_waddr;
   assign wb_data = rf_wdata;

   // Flush of the younger stages rules out back-to-back redirects
   a_no_double_branch: assert property (@(posedge clk) disable iff (!arst_n)
      branch_taken |=> !branch_taken)
      else $error("Branch taken from a flushed instruction");

endmodule

// File: hdl/mips_pkg.sv
// Shared widths, opcode, funct, ALU-operation and branch types for the MIPS pipeline and its testbench
package mips_pkg;

   // Machine word and register index widths
   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [15:0]           imm_t;

   // Primary opcodes, standard MIPS encoding
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_t;

   // R-type function field
   typedef enum logic [5:0] {
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_SLT = 6'h2a
   } funct_t;

   // ALU operations, SLT compares signed
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_t;

   // Branch kind carried down to the memory stage
   typedef enum logic [1:0] {
      BR_NONE = 2'd0,
      BR_EQ   = 2'd1,
      BR_NE   = 2'd2
   } branch_t;

endpackage

// File: hdl/mips_regfile.sv
// 32-entry register file, two combinational read ports and one write port with bypass
`timescale 1ns/1ns

module mips_regfile (
   input  logic                clk,
   input  logic                arst_n,
   input  mips_pkg::reg_addr_t rs,
   input  mips_pkg::reg_addr_t rt,
   input  logic                rf_we,
   input  mips_pkg::reg_addr_t rf_waddr,
   input  mips_pkg::word_t     rf_wdata,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);
   mips_pkg::word_t regs [32];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_we) begin
         regs[rf_waddr] <= rf_wdata;
      end
   end

   // Register 0 reads zero, a same-cycle write is passed straight through
   assign rs_data = (rs == '0) ? '0 :
                    (rf_we && rf_waddr == rs) ? rf_wdata : regs[rs];
   assign rt_data = (rt == '0) ? '0 :
                    (rf_we && rf_waddr == rt) ? rf_wdata : regs[rt];

   // Decode drops writes to r0 three stages earlier
   a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
      !(rf_we && rf_waddr == '0))
      else $error("Write to register 0 reached the register file");

endmodule

// File: mips_cpu.f
+incdir+tb
hdl/mips_pkg.sv
hdl/mips_fetch.sv
hdl/mips_regfile.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_memory.sv
hdl/mips_cpu.sv
tb/mips_cpu_tb.sv

// File: tb/mips_prog_gen.svh
// Random program generator and ISA reference model, included inside the MIPS testbench module
`ifndef MIPS_PROG_GEN_SVH
`define MIPS_PROG_GEN_SVH

   localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

   mips_pkg::word_t     lfsr_state = 32'h6046892e;
   // Program under test and the expected writeback trace
   mips_pkg::word_t     prog [$];
   mips_pkg::reg_addr_t exp_reg [$];
   mips_pkg::word_t     exp_data [$];

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 32'h80200003;
      end
      return b;
   endfunction

   function automatic mips_pkg::word_t rand_bits(input int n);
      mips_pkg::word_t v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   // Standard MIPS field layout, shamt always zero
   function automatic mips_pkg::word_t enc_rtype(input mips_pkg::funct_t f,
         input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
         input mips_pkg::reg_addr_t rt);
      return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, f};
   endfunction

   function automatic mips_pkg::word_t enc_itype(input mips_pkg::opcode_t op,
         input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs, input mips_pkg::imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   // Registers r0..r7 only, so dependences are frequent
   task automatic gen_random(input int len);
      mips_pkg::reg_addr_t a;
      mips_pkg::reg_addr_t b;
      mips_pkg::reg_addr_t c;
      mips_pkg::imm_t      off;
      int                  kind;
      for (int i = 0; i < len; i++) begin
         kind = int'(rand_bits(4));
         a    = mips_pkg::reg_addr_t'(rand_bits(3));
         b    = mips_pkg::reg_addr_t'(rand_bits(3));
         c    = mips_pkg::reg_addr_t'(rand_bits(3));
         case (kind)
            0: prog.push_back(enc_rtype(mips_pkg::F_ADD, a, b, c));
            1: prog.push_back(enc_rtype(mips_pkg::F_SUB, a, b, c));
            2: prog.push_back(enc_rtype(mips_pkg::F_AND, a, b, c));
            3: prog.push_back(enc_rtype(mips_pkg::F_OR, a, b, c));
            4: prog.push_back(enc_rtype(mips_pkg::F_SLT, a, b, c));
            7, 8, 9, 10: begin
               // Base r0, word offset inside the data memory
               off = mips_pkg::imm_t'(rand_bits(DMEM_IDX_W) << 2);
               if (kind < 9) begin
                  prog.push_back(enc_itype(mips_pkg::OP_LW, a, 5'd0, off));
               end else begin
                  prog.push_back(enc_itype(mips_pkg::OP_SW, a, 5'd0, off));
               end
            end
            // Forward-only offsets 0 to 3
            11: prog.push_back(enc_itype(mips_pkg::OP_BEQ, a, b, mips_pkg::imm_t'(rand_bits(2))));
            12: prog.push_back(enc_itype(mips_pkg::OP_BNE, a, b, mips_pkg::imm_t'(rand_bits(2))));
            13: prog.push_back('0);
            default: prog.push_back(enc_itype(mips_pkg::OP_ADDI, a, b,
                                              mips_pkg::imm_t'(rand_bits(16))));
         endcase
      end
   endtask

   // ISA-level run of prog, no delay slots, fills the expected trace
   task automatic model_program();
      mips_pkg::word_t     regs [32];
      mips_pkg::word_t     dmem [DMEM_WORDS];
      mips_pkg::word_t     ins;
      mips_pkg::word_t     x;
      mips_pkg::word_t     y;
      mips_pkg::word_t     simm;
      mips_pkg::word_t     addr;
      mips_pkg::word_t     val;
      mips_pkg::reg_addr_t dest;
      logic                wr;
      int                  i;
      foreach (regs[k]) begin
         regs[k] = '0;
      end
      foreach (dmem[k]) begin
         dmem[k] = '0;
      end
      exp_reg.delete();
      exp_data.delete();
      i = 0;
      // Targets past the end only hit zero words
      while (i < prog.size()) begin
         ins  = prog[i];
         x    = regs[ins[25:21]];
         y    = regs[ins[20:16]];
         simm = {{16{ins[15]}}, ins[15:0]};
         addr = x + simm;
         dest = ins[20:16];
         val  = '0;
         wr   = 1'b0;
         i    = i + 1;
         case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
               dest = ins[15:11];
               wr   = 1'b1;
               case (ins[5:0])
                  mips_pkg::F_ADD: val = x + y;
                  mips_pkg::F_SUB: val = x - y;
                  mips_pkg::F_AND: val = x & y;
                  mips_pkg::F_OR:  val = x | y;
                  mips_pkg::F_SLT: val = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
                  default:         wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDI: begin
               val = addr;
               wr  = 1'b1;
            end
            // Word index is address bits above bit 1
            mips_pkg::OP_LW: begin
               val = dmem[addr[DMEM_IDX_W+1:2]];
               wr  = 1'b1;
            end
            mips_pkg::OP_SW: dmem[addr[DMEM_IDX_W+1:2]] = y;
            mips_pkg::OP_BEQ: i = (x == y) ? i + int'(simm) : i;
            mips_pkg::OP_BNE: i = (x != y) ? i + int'(simm) : i;
            default: ;
         endcase
         // r0 stays zero and never shows on the trace
         if (wr && dest != 5'd0) begin
            regs[dest] = val;
            exp_reg.push_back(dest);
            exp_data.push_back(val);
         end
      end
   endtask

`endif

// File: tb/mips_cpu_tb.sv
// Testbench for the MIPS pipeline, loads programs and checks the writeback trace against a model
`timescale 1ns/1ns

module mips_cpu_tb;
   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 32;
   localparam int IDX_W      = $clog2(IMEM_WORDS);
   localparam int PROG_MAX   = 24;
   localparam int N_RANDOM   = 12;
   localparam int N_TESTS    = 4 + N_RANDOM;
   // Loading, worst-case stalls and flushes, the tail and some slack
   localparam int TEST_CYCLES = IMEM_WORDS + 2 * PROG_MAX + 60;

   logic                clk = 1'b0;
   logic                arst_n;
   logic                imem_we;
   logic [IDX_W-1:0]    imem_addr;
   mips_pkg::word_t     imem_wdata;
   mips_pkg::word_t     pc;
   logic                wb_en;
   mips_pkg::reg_addr_t wb_reg;
   mips_pkg::word_t     wb_data;

   int   errors       = 0;
   int   tests_passed = 0;
   int   tests_failed = 0;
   logic checking     = 1'b0;

   `include "mips_prog_gen.svh"

   mips_cpu #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) mips_cpu_inst (.*);

   // 4 ns period
   always #2 clk = ~clk;

   task automatic check_word(input string name, input mips_pkg::word_t got,
         input mips_pkg::word_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input mips_pkg::reg_addr_t got,
         input mips_pkg::reg_addr_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t %s got r%0d expected r%0d", $time, name, got, exp);
      end
   endtask

   // Trace sampled mid-cycle, away from the rising edge
   always @(negedge clk) begin
      if (!arst_n && wb_en !== 1'b0) begin
         errors++;
         $display("wb_en was not low during reset at %0t", $time);
      end else if (checking && wb_en === 1'b1) begin
         if (exp_reg.size() == 0) begin
            errors++;
            $display("Unexpected register write at %0t, r%0d <= %h", $time, wb_reg, wb_data);
         end else begin
            check_reg("wb_reg", wb_reg, exp_reg.pop_front());
            check_word("wb_data", wb_data, exp_data.pop_front());
         end
      end
   end

   // Reset, reload instruction memory, run until the trace is drained
   task automatic run_test(input string name);
      int errs_before;
      int n_exp;
      int limit;
      errs_before = errors;
      model_program();
      n_exp = exp_reg.size();
      @(posedge clk);
      #1;
      arst_n = 1'b0;
      // Program first, zero words for the rest
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem_we    = 1'b1;
         imem_addr  = IDX_W'(i);
         imem_wdata = (i < prog.size()) ? prog[i] : '0;
         @(posedge clk);
         #1;
      end
      imem_we  = 1'b0;
      arst_n   = 1'b1;
      checking = 1'b1;
      check_word("pc", pc, '0);
      limit = 2 * prog.size() + 30;
      while (exp_reg.size() != 0 && limit > 0) begin
         @(posedge clk);
         limit--;
      end
      // Window for stray writes after the last expected one
      repeat (20) @(posedge clk);
      #1;
      checking = 1'b0;
      if (exp_reg.size() != 0) begin
         errors++;
         $display("Test %s ended with %0d expected register writes missing",
                  name, exp_reg.size());
      end
      if (errors == errs_before) begin
         tests_passed++;
         $display("Test %-16s ok, %0d writes", name, n_exp);
      end else begin
         tests_failed++;
         $display("Test %-16s failed, %0d errors", name, errors - errs_before);
      end
      prog.delete();
   endtask

   initial begin
      #(N_TESTS * TEST_CYCLES * 4);
      $display("Watchdog expired at %0t, the tests did not finish", $time);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      arst_n     = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;

      // Dependent chain, operands from memory and writeback stages
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfffd));
      prog.push_back(enc_rtype(mips_pkg::F_ADD, 5'd3, 5'd1, 5'd2));
      prog.push_back(enc_rtype(mips_pkg::F_SUB, 5'd4, 5'd3, 5'd1));
      prog.push_back(enc_rtype(mips_pkg::F_AND, 5'd5, 5'd4, 5'd3));
      prog.push_back(enc_rtype(mips_pkg::F_OR, 5'd6, 5'd5, 5'd4));
      // Signed compare both ways
      prog.push_back(enc_rtype(mips_pkg::F_SLT, 5'd7, 5'd2, 5'd1));
      prog.push_back(enc_rtype(mips_pkg::F_SLT, 5'd8, 5'd1, 5'd2));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd9, 5'd7, 16'd100));
      prog.push_back(enc_rtype(mips_pkg::F_ADD, 5'd10, 5'd9, 5'd6));
      run_test("forward_chain");

      // Store then dependent loads, each load used at once
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd77));
      prog.push_back(enc_itype(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd8));
      prog.push_back(enc_itype(mips_pkg::OP_LW, 5'd2, 5'd0, 16'd8));
      prog.push_back(enc_rtype(mips_pkg::F_ADD, 5'd3, 5'd2, 5'd1));
      prog.push_back(enc_itype(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd12));
      prog.push_back(enc_itype(mips_pkg::OP_LW, 5'd5, 5'd0, 16'd12));
      // Load result as store data
      prog.push_back(enc_itype(mips_pkg::OP_SW, 5'd5, 5'd0, 16'd16));
      prog.push_back(enc_itype(mips_pkg::OP_LW, 5'd6, 5'd0, 16'd16));
      prog.push_back(enc_rtype(mips_pkg::F_SUB, 5'd7, 5'd6, 5'd2));
      run_test("load_use");

      // Taken beq, untaken bne, taken bne, untaken beq, offset 0
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd4));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd4));
      prog.push_back(enc_itype(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'd1));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'd2));
      prog.push_back(enc_itype(mips_pkg::OP_BNE, 5'd2, 5'd1, 16'd1));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd5, 5'd0, 16'd3));
      prog.push_back(enc_itype(mips_pkg::OP_BNE, 5'd0, 5'd1, 16'd3));
      repeat (3) prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd6, 5'd0, 16'd6));
      prog.push_back(enc_itype(mips_pkg::OP_BEQ, 5'd0, 5'd1, 16'd1));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd7, 5'd1, 16'd9));
      prog.push_back(enc_itype(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'd0));
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd8, 5'd7, 16'd1));
      run_test("branches");

      // r0 targets, zero word, unknown funct and opcode
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd0, 5'd0, 16'd55));
      prog.push_back(enc_rtype(mips_pkg::F_ADD, 5'd3, 5'd0, 5'd0));
      prog.push_back('0);
      prog.push_back({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f});
      prog.push_back({6'h3f, 5'd1, 5'd1, 16'd1});
      prog.push_back(enc_itype(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd7));
      prog.push_back(enc_rtype(mips_pkg::F_SUB, 5'd0, 5'd2, 5'd0));
      prog.push_back(enc_rtype(mips_pkg::F_OR, 5'd4, 5'd0, 5'd2));
      run_test("reg_zero");

      for (int n = 0; n < N_RANDOM; n++) begin
         gen_random(PROG_MAX);
         run_test($sformatf("random_%0d", n));
      end

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
